/* verilog.f */
+incdir+sim
common/rob_pkg.sv
rob/rob_queue.sv
rob/squash_arbiter.sv
rob/commit_select.sv
rob/retire_ctrl.sv
design/rob_top.sv
sim/tb_rob.sv

/* sim/rob_model.svh */
// one model entry per allocated instruction, oldest at the front
typedef struct {
    logic [rob_pkg::XLEN-1:0]   pc;
    logic [rob_pkg::LREG_W-1:0] rd;
    logic [rob_pkg::PTR_W-1:0]  idx;
    logic                       done;
} model_entry_t;

model_entry_t                m_q[$];
logic [rob_pkg::PTR_W-1:0]   m_head;
logic [rob_pkg::PTR_W-1:0]   m_tail;
// pending event kind, 0 none, 1 mispredict, 2 exception
int                          m_hkind;
logic [rob_pkg::PTR_W-1:0]   m_hidx;
logic [rob_pkg::XLEN-1:0]    m_hpc;
logic [rob_pkg::CAUSE_W-1:0] m_hcause;
logic                        m_trap_state;
logic                        m_trap_vld;
logic [rob_pkg::XLEN-1:0]    m_trap_epc;
logic [rob_pkg::CAUSE_W-1:0] m_trap_cause;
logic                        m_sq_vld;
logic [rob_pkg::XLEN-1:0]    m_sq_pc;
logic                        m_sq_br;
int                          m_n;
logic                        m_hit_ex;
logic                        m_hit_mis;
logic                        m_can_enq;
logic                        m_accepted;
int                          n_override;

// distance from the head, smaller means older
function automatic logic [rob_pkg::PTR_W-1:0] age_of(logic [rob_pkg::PTR_W-1:0] idx);
    return idx - m_head;
endfunction

task automatic model_reset();
    m_q.delete();
    m_head       = '0;
    m_tail       = '0;
    m_hkind      = 0;
    m_trap_state = 1'b0;
    m_trap_vld   = 1'b0;
    m_sq_vld     = 1'b0;
    m_sq_br      = 1'b0;
    n_override   = 0;
endtask

// expected outputs for the current cycle
task automatic model_eval();
    logic stall;
    logic stop;
    stall     = m_trap_state || m_sq_vld;
    m_can_enq = (rob_pkg::ROB_DEPTH - m_q.size() >= rob_pkg::ENQ_WIDTH) && !stall;
    m_n       = 0;
    m_hit_ex  = 1'b0;
    m_hit_mis = 1'b0;
    stop      = stall;
    for (int k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin
        if (!stop && k < m_q.size()) begin
            if (m_hkind == 2 && m_q[k].idx == m_hidx) begin
                // faulting entry stays in the buffer
                m_hit_ex = 1'b1;
                stop     = 1'b1;
            end else if (!m_q[k].done) begin
                stop = 1'b1;
            end else begin
                m_n++;
                if (m_hkind == 1 && m_q[k].idx == m_hidx) begin
                    m_hit_mis = 1'b1;
                    stop      = 1'b1;
                end
            end
        end
    end
endtask

// state after the rising edge, given the inputs driven this cycle
task automatic model_step();
    logic                      flush;
    logic                      ev_br;
    logic                      ev_ex;
    logic                      take_ex;
    logic [rob_pkg::PTR_W-1:0] c_idx;
    model_entry_t              e;
    flush      = m_sq_vld;
    m_accepted = (|enq.vld) && m_can_enq;
    m_trap_vld = 1'b0;
    m_sq_vld   = 1'b0;
    if (m_trap_state) begin
        m_trap_state = 1'b0;
        m_sq_vld     = 1'b1;
        m_sq_pc      = tvec;
        m_sq_br      = 1'b0;
    end else if (m_hit_ex) begin
        m_trap_state = 1'b1;
        m_trap_vld   = 1'b1;
        m_trap_epc   = m_q[m_n].pc;
        m_trap_cause = m_hcause;
    end else if (m_hit_mis) begin
        m_sq_vld = 1'b1;
        m_sq_pc  = m_hpc;
        m_sq_br  = 1'b1;
    end
    if (flush) begin
        m_q.delete();
        m_head  = '0;
        m_tail  = '0;
        m_hkind = 0;
    end else begin
        // oldest event wins, exception on a tie
        ev_br   = br_wb.vld && br_wb.mispred;
        ev_ex   = ex_wb.vld;
        take_ex = ev_ex && !(ev_br && age_of(br_wb.idx) < age_of(ex_wb.idx));
        c_idx   = take_ex ? ex_wb.idx : br_wb.idx;
        if ((ev_br || ev_ex) && (m_hkind == 0 || age_of(c_idx) < age_of(m_hidx))) begin
            if (m_hkind != 0 && m_hkind != (take_ex ? 2 : 1)) begin
                n_override++;
            end
            m_hkind = take_ex ? 2 : 1;
            m_hidx  = c_idx;
            if (take_ex) begin
                m_hcause = ex_wb.cause;
            end else begin
                m_hpc = br_wb.npc;
            end
        end
        for (int i = 0; i < m_q.size(); i++) begin
            for (int p = 0; p < rob_pkg::WB_PORTS; p++) begin
                if (wb[p].vld && wb[p].idx == m_q[i].idx) begin
                    m_q[i].done = 1'b1;
                end
            end
            if (br_wb.vld && br_wb.idx == m_q[i].idx) begin
                m_q[i].done = 1'b1;
            end
        end
        for (int k = 0; k < m_n; k++) begin
            void'(m_q.pop_front());
        end
        m_head = m_head + rob_pkg::PTR_W'(m_n);
        for (int k = 0; k < rob_pkg::ENQ_WIDTH; k++) begin
            if (m_accepted && enq.vld[k]) begin
                e.pc   = enq.entry[k].pc;
                e.rd   = enq.entry[k].rd;
                e.idx  = m_tail;
                e.done = 1'b0;
                m_q.push_back(e);
                m_tail = m_tail + rob_pkg::PTR_W'(1);
            end
        end
    end
endtask

/* sim/tb_rob.sv */
`timescale 1ns/100ps

module tb_rob;

    localparam int CYCLES    = 4000;
    localparam int IDLE_MAX  = 400;
    localparam int DRAIN_MAX = 500;

    logic                                       clk;
    logic                                       rst;
    rob_pkg::enq_req_t                          enq;
    rob_pkg::wb_t [rob_pkg::WB_PORTS-1:0]       wb;
    rob_pkg::branch_wb_t                        br_wb;
    rob_pkg::except_wb_t                        ex_wb;
    logic [rob_pkg::XLEN-1:0]                   tvec;
    logic                                       can_enq;
    rob_pkg::rob_idx_t [rob_pkg::ENQ_WIDTH-1:0] alloc_idx;
    rob_pkg::commit_t                           commit;
    rob_pkg::trap_t                             trap;
    rob_pkg::squash_t                           squash;

    logic [31:0] seed;
    logic        pend_vld;
    logic [31:0] picked;
    int          n_mismatch;
    int          n_other;
    int          n_commits;
    int          n_traps;
    int          n_br_squash;
    int          n_ex_squash;
    int          n_full;
    int          idle;
    bit          aborted;

    `include "rob_model.svh"

    rob_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .i_enq       (enq),
        .i_wb        (wb),
        .i_branch_wb (br_wb),
        .i_except_wb (ex_wb),
        .i_tvec      (tvec),
        .o_can_enq   (can_enq),
        .o_alloc_idx (alloc_idx),
        .o_commit    (commit),
        .o_trap      (trap),
        .o_squash    (squash)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            n_mismatch++;
            $display("MISMATCH %s expected %0h actual %0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic require_seen(input string what, input int count);
        if (count == 0) begin
            $display("coverage hole: no %s happened during the run", what);
            n_other++;
        end
    endtask

    // random outstanding entry that is not done and not yet targeted this cycle
    function automatic bit pick_open(output int pos);
        int size;
        int start;
        size = m_q.size();
        pos  = 0;
        if (size == 0) begin
            return 1'b0;
        end
        start = int'(next_rand() % 32'(size));
        for (int k = 0; k < size; k++) begin
            pos = (start + k) % size;
            if (!m_q[pos].done && !picked[pos]) begin
                picked[pos] = 1'b1;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_outputs();
        check_equal("can_enq", m_can_enq, can_enq);
        check_equal("alloc_idx", {m_tail + rob_pkg::PTR_W'(1), m_tail}, alloc_idx);
        check_equal("commit_vld", (1 << m_n) - 1, commit.vld);
        for (int k = 0; k < m_n; k++) begin
            check_equal($sformatf("commit_pc[%0d]", k), m_q[k].pc, commit.pc[k]);
            check_equal($sformatf("commit_rd[%0d]", k), m_q[k].rd, commit.rd[k]);
        end
        check_equal("trap_vld", m_trap_vld, trap.vld);
        if (m_trap_vld) begin
            check_equal("trap_epc", m_trap_epc, trap.epc);
            check_equal("trap_cause", m_trap_cause, trap.cause);
        end
        check_equal("squash_vld", m_sq_vld, squash.vld);
        if (m_sq_vld) begin
            check_equal("squash_pc", m_sq_pc, squash.pc);
            check_equal("squash_branch", m_sq_br, squash.due_to_branch);
        end
        n_commits = n_commits + m_n;
        n_traps   = n_traps + int'(m_trap_vld);
        if (m_sq_vld && m_sq_br) begin
            n_br_squash++;
        end
        if (m_sq_vld && !m_sq_br) begin
            n_ex_squash++;
        end
        if (!m_can_enq && !m_trap_state && !m_sq_vld) begin
            n_full++;
        end
    endtask

    // quiet holds back completions so the buffer fills up
    task automatic drive_inputs(input bit quiet, input bit drain);
        logic [31:0] r;
        int          pos;
        picked = '0;
        r      = next_rand();
        if (!pend_vld && !drain && r[1:0] != 2'b00) begin
            pend_vld = 1'b1;
            enq.vld  = r[2] ? 2'b11 : 2'b01;
            for (int k = 0; k < rob_pkg::ENQ_WIDTH; k++) begin
                enq.entry[k].pc     = next_rand();
                r                   = next_rand();
                enq.entry[k].rd     = r[rob_pkg::LREG_W-1:0];
                enq.entry[k].has_rd = r[31];
            end
        end
        if (!pend_vld) begin
            enq.vld = '0;
        end
        for (int p = 0; p < rob_pkg::WB_PORTS; p++) begin
            wb[p] = '0;
            r     = next_rand();
            if (!quiet && (drain || r[0])) begin
                if (pick_open(pos)) begin
                    wb[p].vld = 1'b1;
                    wb[p].idx = m_q[pos].idx;
                end
            end
        end
        br_wb = '0;
        r     = next_rand();
        if (!quiet && !drain && r[2:0] == 3'd0) begin
            if (pick_open(pos)) begin
                br_wb.vld     = 1'b1;
                br_wb.idx     = m_q[pos].idx;
                br_wb.mispred = r[3] & r[4];
                br_wb.npc     = next_rand();
            end
        end
        ex_wb = '0;
        r     = next_rand();
        if (!quiet && !drain && r[5:0] == 6'd0) begin
            if (pick_open(pos)) begin
                ex_wb.vld   = 1'b1;
                ex_wb.idx   = m_q[pos].idx;
                ex_wb.cause = r[11:8];
            end
        end
        tvec = next_rand();
    endtask

    task automatic run_cycle(input bit quiet, input bit drain);
        logic progress;
        model_eval();
        check_outputs();
        progress = (m_n != 0) || m_sq_vld;
        drive_inputs(quiet, drain);
        model_step();
        if (m_accepted) begin
            pend_vld = 1'b0;
        end
        idle = progress ? 0 : idle + 1;
        @(negedge clk);
    endtask

    initial begin
        int wait_cnt;
        seed        = 32'hf8a1_a2aa;
        rst         = 1'b1;
        enq         = '0;
        wb          = '0;
        br_wb       = '0;
        ex_wb       = '0;
        tvec        = '0;
        pend_vld    = 1'b0;
        picked      = '0;
        n_mismatch  = 0;
        n_other     = 0;
        n_commits   = 0;
        n_traps     = 0;
        n_br_squash = 0;
        n_ex_squash = 0;
        n_full      = 0;
        idle        = 0;
        aborted     = 1'b0;
        model_reset();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < CYCLES && !aborted; c++) begin
            run_cycle((c % 256) < 48, 1'b0);
            if (idle > IDLE_MAX) begin
                $display("timeout: no commit or squash for %0d cycles", IDLE_MAX);
                n_other++;
                aborted = 1'b1;
            end
        end
        // complete everything that is left and wait for the buffer to empty
        wait_cnt = 0;
        while (!aborted && (m_q.size() != 0 || pend_vld || m_trap_state || m_sq_vld)) begin
            run_cycle(1'b0, 1'b1);
            wait_cnt++;
            if (wait_cnt > DRAIN_MAX) begin
                $display("timeout: buffer did not drain within %0d cycles", DRAIN_MAX);
                n_other++;
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            model_eval();
            check_outputs();
        end
        require_seen("retirement", n_commits);
        require_seen("trap report", n_traps);
        require_seen("branch squash", n_br_squash);
        require_seen("trap vector squash", n_ex_squash);
        require_seen("full buffer", n_full);
        require_seen("older event takeover", n_override);
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* design/rob_top.sv */
`timescale 1ns/100ps

module rob_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  rob_pkg::enq_req_t                          i_enq,
    input  rob_pkg::wb_t [rob_pkg::WB_PORTS-1:0]       i_wb,
    input  rob_pkg::branch_wb_t                        i_branch_wb,
    input  rob_pkg::except_wb_t                        i_except_wb,
    input  logic [rob_pkg::XLEN-1:0]                   i_tvec,
    output logic                                       o_can_enq,
    output rob_pkg::rob_idx_t [rob_pkg::ENQ_WIDTH-1:0] o_alloc_idx,
    output rob_pkg::commit_t                           o_commit,
    output rob_pkg::trap_t                             o_trap,
    output rob_pkg::squash_t                           o_squash
);

    rob_pkg::enq_req_t                              enq_gated;
    logic                                           q_can_enq;
    rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0] head_entry;
    rob_pkg::rob_idx_t [rob_pkg::COMMIT_WIDTH-1:0]   head_idx;
    logic [rob_pkg::COMMIT_WIDTH-1:0]               head_vld;
    logic [rob_pkg::COMMIT_WIDTH-1:0]               head_done;
    logic [rob_pkg::COMMIT_WIDTH-1:0]               commit_mask;
    rob_pkg::squash_handle_t                        handle;
    logic                                           hit_mispred;
    logic                                           hit_except;
    logic [rob_pkg::SLOT_W-1:0]                     last_slot;
    logic [rob_pkg::SLOT_W-1:0]                     except_slot;
    logic                                           stall;
    logic                                           flush;

    // hold off allocation while a trap or squash is in progress
    assign enq_gated.vld   = stall ? '0 : i_enq.vld;
    assign enq_gated.entry = i_enq.entry;
    assign o_can_enq       = q_can_enq && !stall;

    rob_queue u_queue (
        .clk           (clk),
        .rst           (rst),
        .i_enq         (enq_gated),
        .i_wb          (i_wb),
        .i_branch_wb   (i_branch_wb),
        .i_commit_mask (commit_mask),
        .i_flush       (flush),
        .o_can_enq     (q_can_enq),
        .o_alloc_idx   (o_alloc_idx),
        .o_head_entry  (head_entry),
        .o_head_idx    (head_idx),
        .o_head_vld    (head_vld),
        .o_head_done   (head_done)
    );

    squash_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_branch_wb (i_branch_wb),
        .i_except_wb (i_except_wb),
        .i_flush     (flush),
        .o_handle    (handle)
    );

    commit_select u_select (
        .clk           (clk),
        .rst           (rst),
        .i_head_vld    (head_vld),
        .i_head_done   (head_done),
        .i_head_idx    (head_idx),
        .i_handle      (handle),
        .i_stall       (stall),
        .o_commit_mask (commit_mask),
        .o_hit_mispred (hit_mispred),
        .o_hit_except  (hit_except),
        .o_last_slot   (last_slot)
    );

    // faulting entry sits just past the last retiring slot
    assign except_slot = commit_mask[0] ? rob_pkg::SLOT_W'(last_slot + 1'b1) : '0;

    retire_ctrl u_retire (
        .clk           (clk),
        .rst           (rst),
        .i_hit_mispred (hit_mispred),
        .i_hit_except  (hit_except),
        .i_handle      (handle),
        .i_except_pc   (head_entry[except_slot].pc),
        .i_tvec        (i_tvec),
        .o_stall       (stall),
        .o_flush       (flush),
        .o_trap        (o_trap),
        .o_squash      (o_squash)
    );

    assign o_commit.vld = commit_mask;
    for (genvar k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin : g_commit
        assign o_commit.pc[k] = head_entry[k].pc;
        assign o_commit.rd[k] = head_entry[k].rd;
    end

endmodule

/* rob/retire_ctrl.sv */
`timescale 1ns/100ps

module retire_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_hit_mispred,
    input  logic                         i_hit_except,
    input  rob_pkg::squash_handle_t      i_handle,
    input  logic [rob_pkg::XLEN-1:0]     i_except_pc,
    input  logic [rob_pkg::XLEN-1:0]     i_tvec,
    output logic                         o_stall,
    output logic                         o_flush,
    output rob_pkg::trap_t               o_trap,
    output rob_pkg::squash_t             o_squash
);

    typedef enum logic {
        ST_NORMAL,
        ST_TRAP
    } state_t;

    state_t                      state;
    logic                        trap_vld;
    logic                        squash_vld;
    logic [rob_pkg::XLEN-1:0]    trap_epc;
    logic [rob_pkg::CAUSE_W-1:0] trap_cause;
    logic [rob_pkg::XLEN-1:0]    sq_pc;
    logic                        sq_branch;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_NORMAL;
            trap_vld   <= 1'b0;
            squash_vld <= 1'b0;
        end else begin
            trap_vld   <= 1'b0;
            squash_vld <= 1'b0;
            case (state)
                ST_NORMAL: begin
                    if (i_hit_except) begin
                        state    <= ST_TRAP;
                        trap_vld <= 1'b1;
                    end else if (i_hit_mispred) begin
                        squash_vld <= 1'b1;
                    end
                end
                // trap reported, redirect to the vector next
                ST_TRAP: begin
                    state      <= ST_NORMAL;
                    squash_vld <= 1'b1;
                end
                default: state <= ST_NORMAL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_NORMAL && i_hit_except) begin
            trap_epc   <= i_except_pc;
            trap_cause <= i_handle.payload.exc.cause;
        end
        if (state == ST_TRAP) begin
            sq_pc     <= i_tvec;
            sq_branch <= 1'b0;
        end else if (i_hit_mispred) begin
            sq_pc     <= i_handle.payload.pc;
            sq_branch <= 1'b1;
        end
    end

    // no retirement while trapping or squashing
    assign o_stall  = (state == ST_TRAP) || squash_vld;
    assign o_flush  = squash_vld;
    assign o_trap   = '{vld: trap_vld, epc: trap_epc, cause: trap_cause};
    assign o_squash = '{vld: squash_vld, pc: sq_pc, due_to_branch: sq_branch};

    // the selector reports no hit while retirement is stalled
    no_hit_while_stalled: assert property (@(posedge clk) disable iff (rst)
        o_stall |-> !(i_hit_except || i_hit_mispred));

endmodule

/* rob/commit_select.sv */
`timescale 1ns/100ps

module commit_select (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]              i_head_vld,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]              i_head_done,
    input  rob_pkg::rob_idx_t [rob_pkg::COMMIT_WIDTH-1:0] i_head_idx,
    input  rob_pkg::squash_handle_t                       i_handle,
    input  logic                                          i_stall,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]              o_commit_mask,
    output logic                                          o_hit_mispred,
    output logic                                          o_hit_except,
    output logic [rob_pkg::SLOT_W-1:0]                    o_last_slot
);

    logic [rob_pkg::COMMIT_WIDTH-1:0] match;
    logic                             is_mis;
    logic                             is_ex;

    assign is_mis = i_handle.kind == rob_pkg::SQ_MISPRED;
    assign is_ex  = i_handle.kind == rob_pkg::SQ_EXCEPT;

    for (genvar k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin : g_match
        assign match[k] = i_head_vld[k] && (i_handle.kind != rob_pkg::SQ_NULL) &&
                          (i_head_idx[k] == i_handle.idx);
    end

    always_comb begin
        logic chain;
        logic prev_mis;
        chain         = !i_stall;
        prev_mis      = 1'b0;
        o_commit_mask = '0;
        o_hit_mispred = 1'b0;
        o_hit_except  = 1'b0;
        o_last_slot   = '0;
        for (int k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin
            // faulting entry reached with everything older retiring
            if (chain && is_ex && match[k]) begin
                o_hit_except = 1'b1;
            end
            o_commit_mask[k] = chain && i_head_vld[k] && i_head_done[k] &&
                               !(is_ex && match[k]) && !prev_mis;
            if (o_commit_mask[k] && is_mis && match[k]) begin
                o_hit_mispred = 1'b1;
            end
            if (o_commit_mask[k]) begin
                o_last_slot = rob_pkg::SLOT_W'(k);
            end
            // nothing younger than a mispredicted branch retires
            prev_mis = is_mis && match[k];
            chain    = o_commit_mask[k];
        end
    end

    // retirement never moves past a pending squash entry
    handle_not_passed: assert property (@(posedge clk) disable iff (rst)
        (i_handle.kind != rob_pkg::SQ_NULL) && i_head_vld[0] && !i_stall
            |-> !rob_pkg::is_older(i_handle.idx, i_head_idx[0]));

endmodule

/* rob/squash_arbiter.sv */
`timescale 1ns/100ps

module squash_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  rob_pkg::branch_wb_t     i_branch_wb,
    input  rob_pkg::except_wb_t     i_except_wb,
    input  logic                    i_flush,
    output rob_pkg::squash_handle_t o_handle
);

    logic                     br_ev;
    logic                     ex_ev;
    logic                     take_ex;
    logic                     replace;
    rob_pkg::squash_handle_t  cand;
    rob_pkg::squash_kind_t    handle_kind;
    rob_pkg::rob_idx_t        handle_idx;
    rob_pkg::squash_payload_u handle_payload;

    assign br_ev   = i_branch_wb.vld && i_branch_wb.mispred;
    assign ex_ev   = i_except_wb.vld;
    // exception wins unless the branch is strictly older
    assign take_ex = ex_ev && !(br_ev && rob_pkg::is_older(i_branch_wb.idx, i_except_wb.idx));

    always_comb begin
        cand.kind       = take_ex ? rob_pkg::SQ_EXCEPT : rob_pkg::SQ_MISPRED;
        cand.idx        = take_ex ? i_except_wb.idx : i_branch_wb.idx;
        cand.payload.pc = i_branch_wb.npc;
        if (take_ex) begin
            cand.payload.pc        = '0;
            cand.payload.exc.cause = i_except_wb.cause;
        end
    end

    assign replace = (ex_ev || br_ev) &&
                     ((handle_kind == rob_pkg::SQ_NULL) || rob_pkg::is_older(cand.idx, handle_idx));

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            handle_kind <= rob_pkg::SQ_NULL;
        end else if (replace) begin
            handle_kind <= cand.kind;
        end
    end

    always_ff @(posedge clk) begin
        if (replace) begin
            handle_idx     <= cand.idx;
            handle_payload <= cand.payload;
        end
    end

    assign o_handle = '{kind: handle_kind, idx: handle_idx, payload: handle_payload};

endmodule

/* rob/rob_queue.sv */
`timescale 1ns/100ps

module rob_queue (
    input  logic                                             clk,
    input  logic                                             rst,
    input  rob_pkg::enq_req_t                                i_enq,
    input  rob_pkg::wb_t [rob_pkg::WB_PORTS-1:0]             i_wb,
    input  rob_pkg::branch_wb_t                              i_branch_wb,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]                 i_commit_mask,
    input  logic                                             i_flush,
    output logic                                             o_can_enq,
    output rob_pkg::rob_idx_t [rob_pkg::ENQ_WIDTH-1:0]       o_alloc_idx,
    output rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0]  o_head_entry,
    output rob_pkg::rob_idx_t [rob_pkg::COMMIT_WIDTH-1:0]    o_head_idx,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]                 o_head_vld,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]                 o_head_done
);

    logic [rob_pkg::PTR_W-1:0]     head_ptr;
    logic [rob_pkg::PTR_W-1:0]     tail_ptr;
    logic [rob_pkg::PTR_W-1:0]     count;
    logic [rob_pkg::PTR_W-1:0]     free_cnt;
    logic [rob_pkg::PTR_W-1:0]     enq_cnt;
    logic [rob_pkg::PTR_W-1:0]     ret_cnt;
    logic                          enq_fire;
    logic [rob_pkg::ROB_DEPTH-1:0] done;
    rob_pkg::rob_entry_t           mem [rob_pkg::ROB_DEPTH];

    // pointer difference wraps cleanly because depth is a power of two
    assign count     = tail_ptr - head_ptr;
    assign free_cnt  = rob_pkg::PTR_W'(rob_pkg::ROB_DEPTH) - count;
    assign o_can_enq = (free_cnt >= rob_pkg::PTR_W'(rob_pkg::ENQ_WIDTH)) && !i_flush;
    assign enq_fire  = (|i_enq.vld) && o_can_enq;

    always_comb begin
        enq_cnt = '0;
        ret_cnt = '0;
        for (int k = 0; k < rob_pkg::ENQ_WIDTH; k++) begin
            enq_cnt = enq_cnt + rob_pkg::PTR_W'(i_enq.vld[k]);
        end
        for (int k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin
            ret_cnt = ret_cnt + rob_pkg::PTR_W'(i_commit_mask[k]);
        end
    end

    for (genvar k = 0; k < rob_pkg::ENQ_WIDTH; k++) begin : g_alloc
        assign o_alloc_idx[k] = rob_pkg::rob_idx_t'(tail_ptr + rob_pkg::PTR_W'(k));
    end

    // head window, slot 0 is the oldest entry
    for (genvar k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin : g_head
        assign o_head_idx[k]   = rob_pkg::rob_idx_t'(head_ptr + rob_pkg::PTR_W'(k));
        assign o_head_vld[k]   = count > rob_pkg::PTR_W'(k);
        assign o_head_done[k]  = done[o_head_idx[k].idx];
        assign o_head_entry[k] = mem[o_head_idx[k].idx];
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < rob_pkg::ENQ_WIDTH; k++) begin
            if (enq_fire && i_enq.vld[k]) begin
                mem[o_alloc_idx[k].idx] <= i_enq.entry[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            done     <= '0;
        end else begin
            head_ptr <= head_ptr + ret_cnt;
            if (enq_fire) begin
                tail_ptr <= tail_ptr + enq_cnt;
            end
            // new entries start not done
            for (int k = 0; k < rob_pkg::ENQ_WIDTH; k++) begin
                if (enq_fire && i_enq.vld[k]) begin
                    done[o_alloc_idx[k].idx] <= 1'b0;
                end
            end
            for (int k = 0; k < rob_pkg::WB_PORTS; k++) begin
                if (i_wb[k].vld) begin
                    done[i_wb[k].idx.idx] <= 1'b1;
                end
            end
            if (i_branch_wb.vld) begin
                done[i_branch_wb.idx.idx] <= 1'b1;
            end
        end
    end

    // an accepted allocation never pushes occupancy past the depth
    occupancy_bound: assert property (@(posedge clk) disable iff (rst)
        enq_fire |=> count <= rob_pkg::PTR_W'(rob_pkg::ROB_DEPTH));

endmodule

/* common/rob_pkg.sv */
package rob_pkg;

    localparam int ROB_DEPTH    = 16;
    localparam int ENQ_WIDTH    = 2;
    localparam int COMMIT_WIDTH = 2;
    localparam int WB_PORTS     = 2;
    localparam int XLEN         = 32;
    localparam int CAUSE_W      = 4;
    localparam int LREG_W       = 5;

    // derived widths
    localparam int IDX_W  = $clog2(ROB_DEPTH);
    localparam int PTR_W  = IDX_W + 1;
    localparam int SLOT_W = (COMMIT_WIDTH > 1) ? $clog2(COMMIT_WIDTH) : 1;

    // flip bit tells two laps of the same slot apart
    typedef struct packed {
        logic             flip;
        logic [IDX_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [LREG_W-1:0] rd;
        logic              has_rd;
    } rob_entry_t;

    typedef struct packed {
        logic [ENQ_WIDTH-1:0]       vld;
        rob_entry_t [ENQ_WIDTH-1:0] entry;
    } enq_req_t;

    typedef struct packed {
        logic     vld;
        rob_idx_t idx;
    } wb_t;

    typedef struct packed {
        logic            vld;
        rob_idx_t        idx;
        logic            mispred;
        logic [XLEN-1:0] npc;
    } branch_wb_t;

    typedef struct packed {
        logic               vld;
        rob_idx_t           idx;
        logic [CAUSE_W-1:0] cause;
    } except_wb_t;

    typedef enum logic [1:0] {
        SQ_NULL    = 2'd0,
        SQ_MISPRED = 2'd1,
        SQ_EXCEPT  = 2'd2
    } squash_kind_t;

    // redirect pc for a mispredict, zero-extended cause for an exception
    typedef union packed {
        logic [XLEN-1:0] pc;
        struct packed {
            logic [XLEN-CAUSE_W-1:0] pad;
            logic [CAUSE_W-1:0]      cause;
        } exc;
    } squash_payload_u;

    typedef struct packed {
        squash_kind_t    kind;
        rob_idx_t        idx;
        squash_payload_u payload;
    } squash_handle_t;

    typedef struct packed {
        logic [COMMIT_WIDTH-1:0]             vld;
        logic [COMMIT_WIDTH-1:0][XLEN-1:0]   pc;
        logic [COMMIT_WIDTH-1:0][LREG_W-1:0] rd;
    } commit_t;

    typedef struct packed {
        logic               vld;
        logic [XLEN-1:0]    epc;
        logic [CAUSE_W-1:0] cause;
    } trap_t;

    typedef struct packed {
        logic            vld;
        logic [XLEN-1:0] pc;
        logic            due_to_branch;
    } squash_t;

    // true when a is older than b
    function automatic logic is_older(rob_idx_t a, rob_idx_t b);
        if (a.flip == b.flip) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

endpackage
